/* Makefile */
SRCS = design/route_pkg.sv design/ps2_receiver.sv design/scan_code_filter.sv \
	design/route_rom.sv design/route_sequencer.sv design/hex_digit.sv \
	design/robot_top.sv tb/robot_top_tb.sv

.PHONY: run clean

run: obj_dir/Vrobot_top_tb
	@out=$$(./obj_dir/Vrobot_top_tb 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

obj_dir/Vrobot_top_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module robot_top_tb -f vlog.f

clean:
	rm -rf obj_dir

/* design/hex_digit.sv */
`default_nettype none
`timescale 1ns/10ps

module hex_digit
(
	input logic [3:0] nibble,
	output route_pkg::seven_seg_t seg
);

	// segment order gfedcba, a lit segment is 0
	always_comb
	begin
		case (nibble)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0010000;
			4'ha: seg = 7'b0001000;
			4'hb: seg = 7'b0000011; // lower case b
			4'hc: seg = 7'b1000110;
			4'hd: seg = 7'b0100001; // lower case d
			4'he: seg = 7'b0000110;
			default: seg = 7'b0001110; // F
		endcase
	end

endmodule

`default_nettype wire

/* design/ps2_receiver.sv */
`default_nettype none
`timescale 1ns/10ps

module ps2_receiver
(
	input logic CLOCK_50,
	input logic rst,
	input logic ps2_clk,
	input logic ps2_dat,
	output route_pkg::scan_code_t code,
	output logic code_valid
);

	import route_pkg::*;

	logic [1:0] clk_sync; // two flop synchronizer, pin enters bit 0
	logic [1:0] dat_sync;
	logic clk_prev; // delayed synced clock for edge detect
	logic clk_fall;
	logic [3:0] bit_cnt; // bits taken so far in the frame
	logic [9:0] shift; // start, data, parity once 10 bits are in
	logic frame_ok;

	assign clk_fall = clk_prev & ~clk_sync[1]; // device changes data on rise

	// shift[0] start, shift[8:1] data lsb first, shift[9] parity
	// incoming bit is the stop bit when the count reaches 10
	assign frame_ok = ~shift[0] & dat_sync[1] & (^shift[9:1]); // odd parity

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			clk_sync <= 2'b11; // bus idles high
			dat_sync <= 2'b11;
			clk_prev <= 1'b1;
		end
		else
		begin
			clk_sync <= {clk_sync[0], ps2_clk};
			dat_sync <= {dat_sync[0], ps2_dat};
			clk_prev <= clk_sync[1];
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			bit_cnt <= 4'd0;
			code_valid <= 1'b0;
		end
		else
		begin
			code_valid <= 1'b0; // single cycle strobe
			if (clk_fall)
			begin
				if (bit_cnt == 4'd10)
				begin
					bit_cnt <= 4'd0; // stop bit, frame done
					code_valid <= frame_ok; // bad frames are dropped silently
				end
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (clk_fall)
		begin
			if (bit_cnt == 4'd10)
				code <= shift[8:1]; // byte out with the strobe
			else
				shift <= {dat_sync[1], shift[9:1]}; // lsb arrives first
		end
	end

	// frame is always 11 bits, count wraps at the stop bit
	bit_cnt_range: assert property (@(posedge CLOCK_50) disable iff (rst) bit_cnt <= 4'd10)
		else $error("ps2 bit count ran past the stop bit");

endmodule

`default_nettype wire

/* design/robot_top.sv */
`default_nettype none
`timescale 1ns/10ps

module robot_top
#(
	parameter int tick_cycles = 25_000_000 // half a second at 50 MHz
)
(
	input logic CLOCK_50,
	input logic rst,
	input logic ps2_clk,
	input logic ps2_dat,
	output route_pkg::motor_drive_t motor,
	output route_pkg::led_t led,
	output route_pkg::seven_seg_t hex0,
	output route_pkg::seven_seg_t hex1
);

	import route_pkg::*;

	scan_code_t code; // received byte
	logic code_valid;
	scan_code_t shown_code; // last make code
	route_id_t route;
	logic start;
	route_id_t route_sel; // rom address
	step_t step;
	segment_t segment; // rom data

	ps2_receiver ps2_receiver_i
	(
		.CLOCK_50 (CLOCK_50),
		.rst (rst),
		.ps2_clk (ps2_clk),
		.ps2_dat (ps2_dat),
		.code (code),
		.code_valid (code_valid)
	);

	scan_code_filter scan_code_filter_i
	(
		.CLOCK_50 (CLOCK_50),
		.rst (rst),
		.code (code),
		.code_valid (code_valid),
		.shown_code (shown_code),
		.route (route),
		.start (start)
	);

	route_rom route_rom_i
	(
		.route_sel (route_sel),
		.step (step),
		.segment (segment)
	);

	route_sequencer #(.tick_cycles (tick_cycles)) route_sequencer_i
	(
		.CLOCK_50 (CLOCK_50),
		.rst (rst),
		.route (route),
		.start (start),
		.segment (segment),
		.route_sel (route_sel),
		.step (step),
		.motor (motor),
		.led (led)
	);

	hex_digit hex_lo_i
	(
		.nibble (shown_code[3:0]), // low nibble on hex0
		.seg (hex0)
	);

	hex_digit hex_hi_i
	(
		.nibble (shown_code[7:4]),
		.seg (hex1)
	);

endmodule

`default_nettype wire

/* design/route_pkg.sv */
`default_nettype none

package route_pkg;

	typedef logic [7:0] scan_code_t; // one ps2 byte

	// enum values line up with the led code so the led is a plain copy
	typedef enum logic [1:0]
	{
		motion_stop    = 2'b00,
		motion_right   = 2'b01,
		motion_left    = 2'b10,
		motion_forward = 2'b11
	} motion_t;

	// gpio bit order of the motor header, bit 5 first
	typedef struct packed
	{
		logic en2; // motor 2 enable
		logic m1_ccw; // motor 1 anticlockwise
		logic m2_cw; // motor 2 clockwise
		logic m1_cw; // motor 1 clockwise
		logic m2_ccw; // motor 2 anticlockwise
		logic en1; // motor 1 enable
	} motor_drive_t;

	typedef logic [1:0] led_t; // motion indicator pair
	typedef logic [3:0] route_id_t; // 0..9 routes
	typedef logic [2:0] step_t; // up to 8 steps per route
	typedef logic [6:0] seven_seg_t; // active low, gfedcba

	localparam route_id_t route_none = 4'hf; // key without a route
	localparam int num_routes = 10;
	localparam scan_code_t break_code = 8'hf0; // key release prefix

	typedef struct packed
	{
		motion_t motion;
		logic [4:0] ticks; // 1..31 ticks
		logic last; // final step of the route
	} segment_t;

	// make code to route number
	function automatic route_id_t route_of(scan_code_t code);
		case (code)
			8'h2d: return 4'd0; // R
			8'h33: return 4'd1; // H
			8'h3a: return 4'd2; // M
			8'h31: return 4'd3; // N
			8'h1b: return 4'd4; // S
			8'h2c: return 4'd5; // T
			8'h3b: return 4'd6; // J
			8'h43: return 4'd7; // I
			8'h1c: return 4'd8; // A
			8'h32: return 4'd9; // B
			default: return route_none;
		endcase
	endfunction

endpackage

`default_nettype wire

/* design/route_rom.sv */
`default_nettype none
`timescale 1ns/10ps

module route_rom
(
	input route_pkg::route_id_t route_sel,
	input route_pkg::step_t step,
	output route_pkg::segment_t segment
);

	import route_pkg::*;

	function automatic segment_t ent(motion_t m, logic [4:0] t, logic l);
		segment_t s;
		s.motion = m;
		s.ticks = t;
		s.last = l;
		return s;
	endfunction

	// 8-tick pivots were the u-turns
	always_comb
	begin
		case ({route_sel, step})
			{4'd0, 3'd0}: segment = ent(motion_forward, 5'd5, 1'b1); // R
			{4'd1, 3'd0}: segment = ent(motion_right, 5'd8, 1'b0); // H
			{4'd1, 3'd1}: segment = ent(motion_forward, 5'd5, 1'b0);
			{4'd1, 3'd2}: segment = ent(motion_right, 5'd8, 1'b1);
			{4'd2, 3'd0}: segment = ent(motion_forward, 5'd1, 1'b0); // M
			{4'd2, 3'd1}: segment = ent(motion_left, 5'd4, 1'b0);
			{4'd2, 3'd2}: segment = ent(motion_forward, 5'd3, 1'b0);
			{4'd2, 3'd3}: segment = ent(motion_right, 5'd4, 1'b0);
			{4'd2, 3'd4}: segment = ent(motion_forward, 5'd2, 1'b1);
			{4'd3, 3'd0}: segment = ent(motion_left, 5'd8, 1'b0); // N
			{4'd3, 3'd1}: segment = ent(motion_forward, 5'd2, 1'b0);
			{4'd3, 3'd2}: segment = ent(motion_left, 5'd4, 1'b0);
			{4'd3, 3'd3}: segment = ent(motion_forward, 5'd3, 1'b0);
			{4'd3, 3'd4}: segment = ent(motion_right, 5'd4, 1'b0);
			{4'd3, 3'd5}: segment = ent(motion_forward, 5'd1, 1'b0);
			{4'd3, 3'd6}: segment = ent(motion_left, 5'd8, 1'b1);
			{4'd4, 3'd0}: segment = ent(motion_left, 5'd8, 1'b0); // S
			{4'd4, 3'd1}: segment = ent(motion_forward, 5'd5, 1'b0);
			{4'd4, 3'd2}: segment = ent(motion_left, 5'd4, 1'b0);
			{4'd4, 3'd3}: segment = ent(motion_forward, 5'd3, 1'b1);
			{4'd5, 3'd0}: segment = ent(motion_left, 5'd8, 1'b0); // T
			{4'd5, 3'd1}: segment = ent(motion_forward, 5'd3, 1'b0);
			{4'd5, 3'd2}: segment = ent(motion_right, 5'd4, 1'b0);
			{4'd5, 3'd3}: segment = ent(motion_forward, 5'd5, 1'b1);
			{4'd6, 3'd0}: segment = ent(motion_right, 5'd8, 1'b0); // J
			{4'd6, 3'd1}: segment = ent(motion_forward, 5'd2, 1'b0);
			{4'd6, 3'd2}: segment = ent(motion_right, 5'd4, 1'b0);
			{4'd6, 3'd3}: segment = ent(motion_forward, 5'd4, 1'b0);
			{4'd6, 3'd4}: segment = ent(motion_left, 5'd4, 1'b0);
			{4'd6, 3'd5}: segment = ent(motion_forward, 5'd3, 1'b1);
			{4'd7, 3'd0}: segment = ent(motion_right, 5'd8, 1'b0); // I
			{4'd7, 3'd1}: segment = ent(motion_forward, 5'd3, 1'b0);
			{4'd7, 3'd2}: segment = ent(motion_right, 5'd4, 1'b0);
			{4'd7, 3'd3}: segment = ent(motion_forward, 5'd4, 1'b0);
			{4'd7, 3'd4}: segment = ent(motion_left, 5'd4, 1'b0);
			{4'd7, 3'd5}: segment = ent(motion_forward, 5'd2, 1'b1);
			{4'd8, 3'd0}: segment = ent(motion_forward, 5'd1, 1'b0); // A
			{4'd8, 3'd1}: segment = ent(motion_right, 5'd4, 1'b0);
			{4'd8, 3'd2}: segment = ent(motion_forward, 5'd3, 1'b1);
			{4'd9, 3'd0}: segment = ent(motion_right, 5'd8, 1'b0); // B
			{4'd9, 3'd1}: segment = ent(motion_forward, 5'd3, 1'b0);
			{4'd9, 3'd2}: segment = ent(motion_right, 5'd4, 1'b0);
			{4'd9, 3'd3}: segment = ent(motion_forward, 5'd4, 1'b0);
			{4'd9, 3'd4}: segment = ent(motion_left, 5'd4, 1'b0);
			{4'd9, 3'd5}: segment = ent(motion_forward, 5'd1, 1'b1);
			default: segment = ent(motion_stop, 5'd0, 1'b1); // past the end or no route
		endcase
	end

	// the sequencer must stop at the last flag, never reading past a route
	always_comb
	begin
		rom_in_range: assert final ($isunknown(route_sel) || route_sel >= num_routes
			|| segment.ticks != 5'd0)
			else $error("route %0d read past its last step", route_sel);
	end

endmodule

`default_nettype wire

/* design/route_sequencer.sv */
`default_nettype none
`timescale 1ns/10ps

module route_sequencer
#(
	parameter int tick_cycles = 25_000_000 // clocks per tick
)
(
	input logic CLOCK_50,
	input logic rst,
	input route_pkg::route_id_t route,
	input logic start,
	input route_pkg::segment_t segment,
	output route_pkg::route_id_t route_sel,
	output route_pkg::step_t step,
	output route_pkg::motor_drive_t motor,
	output route_pkg::led_t led
);

	import route_pkg::*;

	localparam int pre_w = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;
	localparam logic [pre_w-1:0] pre_last = pre_w'(tick_cycles - 1);

	logic active; // a route is playing
	route_id_t route_q; // route being played
	step_t step_q; // step being played
	logic [pre_w-1:0] pre_cnt; // tick prescaler
	logic [4:0] tick_left; // ticks left in this step
	logic cur_last; // current step ends the route
	logic step_done;
	logic advance;
	logic load;

	function automatic motor_drive_t drive_of(motion_t m);
		motor_drive_t d;
		d = '0; // ccw lines never used
		case (m)
			motion_forward:
			begin
				d.en1 = 1'b1;
				d.m1_cw = 1'b1;
				d.en2 = 1'b1;
				d.m2_cw = 1'b1;
			end
			motion_left:
			begin
				d.en1 = 1'b1; // motor 1 only
				d.m1_cw = 1'b1;
			end
			motion_right:
			begin
				d.en2 = 1'b1; // motor 2 only
				d.m2_cw = 1'b1;
			end
			default: d = '0;
		endcase
		return d;
	endfunction

	assign step_done = active && pre_cnt == pre_last && tick_left == 5'd1;
	assign advance = step_done && !cur_last;
	assign load = start || advance; // take a new segment from the rom

	// rom address looks ahead so the loaded segment is the next one
	assign route_sel = start ? route : route_q;
	assign step = start ? step_t'(0) : (advance ? step_q + step_t'(1) : step_q);

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			active <= 1'b0;
			route_q <= route_none;
			step_q <= '0;
			pre_cnt <= '0;
			tick_left <= 5'd0;
			cur_last <= 1'b0;
			motor <= '0; // stopped
			led <= '0;
		end
		else if (load)
		begin
			active <= 1'b1; // start also restarts a running route
			route_q <= route_sel;
			step_q <= step;
			pre_cnt <= '0;
			tick_left <= segment.ticks;
			cur_last <= segment.last;
			motor <= drive_of(segment.motion);
			led <= led_t'(segment.motion); // enum matches led code
		end
		else if (step_done)
		begin
			active <= 1'b0; // last step over, idle
			pre_cnt <= '0;
			motor <= '0;
			led <= '0;
		end
		else if (active)
		begin
			if (pre_cnt == pre_last)
			begin
				pre_cnt <= '0;
				tick_left <= tick_left - 5'd1; // one tick gone
			end
			else
				pre_cnt <= pre_cnt + 1'b1;
		end
	end

	// an h-bridge fed both ways shorts the supply
	no_double_drive: assert property (@(posedge CLOCK_50) disable iff (rst)
		!(motor.m1_cw && motor.m1_ccw) && !(motor.m2_cw && motor.m2_ccw))
		else $error("motor driven in both directions");

endmodule

`default_nettype wire

/* design/scan_code_filter.sv */
`default_nettype none
`timescale 1ns/10ps

module scan_code_filter
(
	input logic CLOCK_50,
	input logic rst,
	input route_pkg::scan_code_t code,
	input logic code_valid,
	output route_pkg::scan_code_t shown_code,
	output route_pkg::route_id_t route,
	output logic start
);

	import route_pkg::*;

	logic break_pend; // F0 seen, swallow next byte
	route_id_t key_route;

	assign key_route = route_of(code); // lookup on the raw byte

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			break_pend <= 1'b0;
			shown_code <= 8'h00; // display reads 00
			route <= route_none;
			start <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			if (code_valid)
			begin
				if (code == break_code)
					break_pend <= 1'b1; // release prefix
				else if (break_pend)
					break_pend <= 1'b0; // released key code, ignore
				else
				begin
					shown_code <= code; // every make code is shown
					route <= key_route;
					start <= key_route != route_none; // unmapped keys leave motion alone
				end
			end
		end
	end

	// sequencer must never be kicked with the no-route id
	start_has_route: assert property (@(posedge CLOCK_50) disable iff (rst)
		start |-> route != route_none)
		else $error("start pulsed without a route");

endmodule

`default_nettype wire

/* tb/robot_top_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module robot_top_tb;

	import route_pkg::*;

	localparam int num_tests = 14;
	localparam int tick_len = 4; // clocks per tick in this bench

	logic CLOCK_50;
	logic rst;
	logic ps2_clk;
	logic ps2_dat;
	motor_drive_t motor;
	led_t led;
	seven_seg_t hex0;
	seven_seg_t hex1;

	int cycles; // watchdog count
	bit frames_sent; // sender is done with the entry's frames

	// frame slot {used, bad parity, byte} with slot 0 sent first
	string test_name [num_tests] = '{"route R", "route H", "route M", "route N", "route S",
		"route T", "route J", "route I", "route A", "route B", "break after N",
		"bad parity", "unmapped key", "restart N to A"};
	logic [2:0][9:0] frames [num_tests] = '{{10'h000, 10'h000, 10'h22d},
		{10'h000, 10'h000, 10'h233}, {10'h000, 10'h000, 10'h23a},
		{10'h000, 10'h000, 10'h231}, {10'h000, 10'h000, 10'h21b},
		{10'h000, 10'h000, 10'h22c}, {10'h000, 10'h000, 10'h23b},
		{10'h000, 10'h000, 10'h243}, {10'h000, 10'h000, 10'h21c},
		{10'h000, 10'h000, 10'h232}, {10'h231, 10'h2f0, 10'h231},
		{10'h000, 10'h000, 10'h31c}, {10'h000, 10'h000, 10'h215},
		{10'h000, 10'h21c, 10'h231}};
	logic [13:0] hex_exp [num_tests] = '{{7'h24, 7'h21}, {7'h30, 7'h30}, {7'h30, 7'h08},
		{7'h30, 7'h79}, {7'h79, 7'h03}, {7'h24, 7'h46}, {7'h30, 7'h03}, {7'h19, 7'h30},
		{7'h79, 7'h46}, {7'h30, 7'h24}, {7'h30, 7'h79}, {7'h30, 7'h79}, {7'h79, 7'h12},
		{7'h79, 7'h46}}; // {hex1, hex0} where a bad frame keeps the previous code
	string motions [num_tests] = '{"F5", "R8F5R8", "F1L4F3R4F2", "L8F2L4F3R4F1L8",
		"L8F5L4F3", "L8F3R4F5", "R8F2R4F4L4F3", "R8F3R4F4L4F2", "F1R4F3",
		"R8F3R4F4L4F1", "L8F2L4F3R4F1L8", "", "", "F1R4F3"}; // motion and ticks
	bit restart [num_tests] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1};

	robot_top #(.tick_cycles (tick_len)) robot_top_i
	(
		.CLOCK_50 (CLOCK_50),
		.rst (rst),
		.ps2_clk (ps2_clk),
		.ps2_dat (ps2_dat),
		.motor (motor),
		.led (led),
		.hex0 (hex0),
		.hex1 (hex1)
	);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #50 CLOCK_50 = ~CLOCK_50; // 100 ns period
	end

	task automatic stop_on_error();
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_motor(input string name, input motor_drive_t exp,
		input motor_drive_t act);
		if (act !== exp)
		begin
			$display("FAIL %s: motor expected %b, got %b", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_led(input string name, input led_t exp, input led_t act);
		if (act !== exp)
		begin
			$display("FAIL %s: led expected %b, got %b", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_hex(input string name, input seven_seg_t exp, input seven_seg_t act);
		if (act !== exp)
		begin
			$display("FAIL %s: segments expected %h, got %h", name, exp, act);
			stop_on_error();
		end
	endtask

	// motor lines for a motion letter with ccw lines low
	function automatic motor_drive_t drive_for(byte c);
		motor_drive_t d;
		d = '0;
		if (c == "F" || c == "L")
		begin
			d.en1 = 1'b1; // motor 1 runs on forward and left
			d.m1_cw = 1'b1;
		end
		if (c == "F" || c == "R")
		begin
			d.en2 = 1'b1;
			d.m2_cw = 1'b1;
		end
		return d;
	endfunction

	function automatic led_t led_for(byte c);
		return {c == "F" || c == "L", c == "F" || c == "R"}; // F 11, L 10, R 01
	endfunction

	// twice the route ticks times tick_len plus 100 per frame
	function automatic int cycle_limit();
		int total;
		total = 0;
		for (int t = 0; t < num_tests; t++)
		begin
			for (int k = 1; k < motions[t].len(); k += 2)
				total += (motions[t][k] - "0") * tick_len;
			for (int s = 0; s < 3; s++)
				if (frames[t][s][9])
					total += 100;
		end
		return total * 2;
	endfunction

	task automatic clocks(input int n);
		repeat (n) @(posedge CLOCK_50);
		#1; // drive just after the edge
	endtask

	// 11 bits lsb first with data set while ps2_clk is high
	task automatic send_frame(input scan_code_t data, input bit bad_parity);
		logic [10:0] bits;
		bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0}; // stop, odd parity, data, start
		for (int i = 0; i < 11; i++)
		begin
			ps2_dat = bits[i];
			clocks(4);
			ps2_clk = 1'b0; // device clock low phase
			clocks(4);
			ps2_clk = 1'b1;
		end
		ps2_dat = 1'b1; // bus idle
	endtask

	task automatic send_entry(input int t);
		for (int s = 0; s < 3; s++)
		begin
			if (frames[t][s][9])
			begin
				clocks(2 + int'($urandom % 16)); // random idle gap
				send_frame(frames[t][s][7:0], frames[t][s][8]);
			end
		end
		frames_sent = 1'b1;
	endtask

	// wait on negedges until motor matches pat (or leaves it)
	task automatic await_motor(input motor_drive_t pat, input bit match, input int limit,
		input string what);
		int waited;
		waited = 0;
		@(negedge CLOCK_50);
		while ((motor === pat) != match)
		begin
			if (waited == limit)
			begin
				$display("%s", what);
				stop_on_error();
			end
			else
			begin
				waited++;
				@(negedge CLOCK_50);
			end
		end
	endtask

	task automatic check_playback(input int t);
		string m;
		m = motions[t];
		if (m.len() == 0)
		begin
			while (!frames_sent)
			begin
				@(negedge CLOCK_50);
				check_motor(test_name[t], '0, motor); // nothing may move
			end
		end
		else
		begin
			if (restart[t])
			begin
				wait (frames_sent);
				if (motor === '0)
				begin
					$display("%s: first route ended before the second key", test_name[t]);
					stop_on_error();
				end
				await_motor(drive_for(m[0]), 1'b1, 20,
					"playback did not restart on the second key");
			end
			else
				await_motor('0, 1'b0, 300, "motor never left stop after a route key");
			for (int k = 0; k < m.len(); k += 2)
			begin
				repeat ((m[k + 1] - "0") * tick_len) // exact segment length
				begin
					check_motor(test_name[t], drive_for(m[k]), motor);
					check_led(test_name[t], led_for(m[k]), led);
					@(negedge CLOCK_50);
				end
			end
			check_motor(test_name[t], '0, motor); // back to stop after the last step
		end
	endtask

	initial
	begin
		int limit;
		limit = cycle_limit();
		cycles = 0;
		forever
		begin
			@(posedge CLOCK_50);
			cycles++;
			if (cycles > limit)
			begin
				$display("run timed out after %0d cycles", cycles);
				stop_on_error();
			end
		end
	end

	initial
	begin
		void'($urandom(32'h025af8e4)); // fixed seed
		rst = 1'b1;
		ps2_clk = 1'b1;
		ps2_dat = 1'b1;
		frames_sent = 1'b0;
		clocks(16);
		rst = 1'b0;
		@(negedge CLOCK_50);
		check_motor("after reset", '0, motor);
		check_led("after reset", '0, led);
		check_hex("after reset hex1", 7'h40, hex1); // 00 on the display
		check_hex("after reset hex0", 7'h40, hex0);
		for (int t = 0; t < num_tests; t++)
		begin
			frames_sent = 1'b0;
			fork
				send_entry(t);
				check_playback(t);
			join
			clocks(10); // any late start would show by now
			@(negedge CLOCK_50);
			check_motor(test_name[t], '0, motor);
			check_hex({test_name[t], " hex1"}, hex_exp[t][13:7], hex1);
			check_hex({test_name[t], " hex0"}, hex_exp[t][6:0], hex0);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
design/route_pkg.sv
design/ps2_receiver.sv
design/scan_code_filter.sv
design/route_rom.sv
design/route_sequencer.sv
design/hex_digit.sv
design/robot_top.sv
tb/robot_top_tb.sv
